// File: spi_regs_tests.txt
# kind rflag addr op data expect bits, all hex except bits
# expect is the read word for R and the addressed register after W and A
R 1 07 0 000000 AAAAAA 40
R 1 08 0 000000 000000 40
R 1 09 0 000000 000000 40
R 1 0C 0 000000 000000 40
R 1 0E 0 000000 000000 40
W 0 07 0 123456 123456 40
W 0 08 0 00A5C3 00A5C3 40
W 0 09 0 F0E1D2 F0E1D2 40
W 0 0C 0 000003 000003 40
W 0 0E 0 5A5A5A 5A5A5A 40
R 1 07 0 000000 123456 40
R 1 08 0 000000 00A5C3 40
W 0 09 1 0F0000 FFE1D2 40
W 0 09 2 00E100 FF00D2 40
W 0 09 3 FFFFFF 00FF2D 40
R 1 09 0 000000 00FF2D 40
R 1 03 0 000000 0F0F0F 40
W 0 14 0 ABCDEF 000000 40
A 0 0E 0 FFFFFF 5A5A5A 20
R 1 0E 0 000000 5A5A5A 40
R 1 0E 0 000000 5A5A5A 40
W 0 0C 0 C0FFEE C0FFEE 40
R 1 0C 0 000000 C0FFEE 40

// File: compile.f
spi_regs_pkg.sv
reg_bus_if.sv
spi_sync.sv
spi_frame_engine.sv
reg_file.sv
spi_regs_top.sv
spi_regs_props.sv
spi_regs_checker.sv
spi_regs_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= spi_regs_tb
LOG ?= sim.log
BUILD_DIR ?= obj_dir
FAIL_MSG ?= Test failures found

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR) -f compile.f
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: spi_regs_tb.sv
// spi register block testbench
// mode 0 spi master fed from a test table, with clock, reset and watchdog
`timescale 1ns/100ps

module spi_regs_tb;

  logic cs = 1'b0;
  logic rst_n;
  logic sclk;
  logic spi_cs_n;
  logic mosi;
  logic miso;
  spi_regs_pkg::reg_data_t reg_led;
  spi_regs_pkg::reg_data_t reg_spi_mux;
  spi_regs_pkg::reg_data_t reg_sr_4094;
  spi_regs_pkg::reg_data_t reg_mode;
  spi_regs_pkg::reg_data_t reg_test_pattern;

  // expected result of the frame in flight
  logic [7:0] exp_kind;
  spi_regs_pkg::reg_addr_t exp_addr;
  spi_regs_pkg::reg_data_t exp_value;
  int err_count;
  int check_count;
  int tb_errors;
  logic tests_loaded = 1'b0;
  integer seed;

  // test table, one entry per line of the file
  logic [7:0] t_kind [$];
  logic t_rflag [$];
  spi_regs_pkg::reg_addr_t t_addr [$];
  spi_regs_pkg::wr_op_t t_op [$];
  spi_regs_pkg::reg_data_t t_data [$];
  spi_regs_pkg::reg_data_t t_exp [$];
  int t_bits [$];

  always #20 cs = ~cs;

  spi_regs_top spi_regs_top_inst (
    .cs               (cs),
    .rst_n            (rst_n),
    .sclk             (sclk),
    .spi_cs_n         (spi_cs_n),
    .mosi             (mosi),
    .miso             (miso),
    .reg_led          (reg_led),
    .reg_spi_mux      (reg_spi_mux),
    .reg_sr_4094      (reg_sr_4094),
    .reg_mode         (reg_mode),
    .reg_test_pattern (reg_test_pattern)
  );

  spi_regs_checker checker_inst (
    .cs               (cs),
    .sclk             (sclk),
    .spi_cs_n         (spi_cs_n),
    .miso             (miso),
    .reg_led          (reg_led),
    .reg_spi_mux      (reg_spi_mux),
    .reg_sr_4094      (reg_sr_4094),
    .reg_mode         (reg_mode),
    .reg_test_pattern (reg_test_pattern),
    .exp_kind         (exp_kind),
    .exp_addr         (exp_addr),
    .exp_value        (exp_value),
    .err_count        (err_count),
    .check_count      (check_count)
  );

  // 8 cs cycles, pins move 2 ns after the edge
  task automatic half_period;
    repeat (8) @(posedge cs);
    #2;
  endtask

  // mode 0, msb first, chip select raised after nbits clocks
  task automatic send_frame(input logic [spi_regs_pkg::FRAME_BITS-1:0] frame, input int nbits);
    spi_cs_n = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      mosi = frame[spi_regs_pkg::FRAME_BITS-1-i];
      half_period();
      sclk = 1'b1;
      half_period();
      sclk = 1'b0;
    end
    half_period();
    spi_cs_n = 1'b1;
    mosi = 1'b0;
  endtask

  task automatic load_tests;
    int fd;
    int n;
    string line;
    logic [7:0] k;
    logic f;
    spi_regs_pkg::reg_addr_t a;
    spi_regs_pkg::wr_op_t o;
    spi_regs_pkg::reg_data_t d;
    spi_regs_pkg::reg_data_t e;
    int b;
    fd = $fopen("spi_regs_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the test file spi_regs_tests.txt");
      tb_errors = tb_errors + 1;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      // skip blank and comment lines
      if (n > 1 && line[0] != "#")
      begin
        n = $sscanf(line, "%c %h %h %h %h %h %d", k, f, a, o, d, e, b);
        if (n == 7)
        begin
          t_kind.push_back(k);
          t_rflag.push_back(f);
          t_addr.push_back(a);
          t_op.push_back(o);
          t_data.push_back(d);
          t_exp.push_back(e);
          t_bits.push_back(b);
        end
        else
        begin
          $display("malformed line in the test file: %s", line);
          tb_errors = tb_errors + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  initial
  begin
    logic [spi_regs_pkg::FRAME_BITS-1:0] frame;
    int prev;
    rst_n = 1'b0;
    sclk = 1'b0;
    spi_cs_n = 1'b1;
    mosi = 1'b0;
    exp_kind = "W";
    exp_addr = '0;
    exp_value = '0;
    seed = 32'h9608;
    tb_errors = 0;
    load_tests();
    if (t_kind.size() == 0)
    begin
      $display("the test file holds no transactions");
      tb_errors = tb_errors + 1;
    end
    tests_loaded = 1'b1;
    repeat (4) @(posedge cs);
    #2;
    rst_n = 1'b1;
    repeat (4) @(posedge cs);
    for (int i = 0; i < t_kind.size(); i++)
    begin
      // flag, address, random pad with the op in its low bits, value
      frame[39] = t_rflag[i];
      frame[38:32] = t_addr[i];
      frame[31:26] = 6'($random(seed));
      frame[25:24] = t_op[i];
      frame[23:0] = (t_kind[i] == "R") ? 24'($random(seed)) : t_data[i];
      exp_kind = t_kind[i];
      exp_addr = t_addr[i];
      exp_value = t_exp[i];
      prev = check_count;
      @(posedge cs);
      #2;
      send_frame(frame, t_bits[i]);
      wait (check_count == prev + 1);
    end
    $display("summary: %0d checker errors, %0d testbench errors, %0d of %0d frames checked",
      err_count, tb_errors, check_count, t_kind.size());
    if (err_count == 0 && tb_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // each line fits in 48 bit times of 16 cs cycles, plus margin for reset
  initial
  begin
    int limit_ns;
    wait (tests_loaded);
    limit_ns = t_kind.size() * 48 * 16 * 40 + 2000;
    #(limit_ns);
    $display("watchdog fired, the tests did not finish within %0d ns", limit_ns);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: spi_regs_checker.sv
// spi register block checker
// assembles read words from miso and compares them and the register outputs
`timescale 1ns/100ps

module spi_regs_checker (
  input  logic cs,
  input  logic sclk,
  input  logic spi_cs_n,
  input  logic miso,
  input  spi_regs_pkg::reg_data_t reg_led,
  input  spi_regs_pkg::reg_data_t reg_spi_mux,
  input  spi_regs_pkg::reg_data_t reg_sr_4094,
  input  spi_regs_pkg::reg_data_t reg_mode,
  input  spi_regs_pkg::reg_data_t reg_test_pattern,
  input  logic [7:0] exp_kind,
  input  spi_regs_pkg::reg_addr_t exp_addr,
  input  spi_regs_pkg::reg_data_t exp_value,
  output int err_count,
  output int check_count
);

  // rises seen while chip select is low
  int bit_cnt;
  spi_regs_pkg::reg_data_t rd_word;
  // register state the test table says the outputs should hold
  spi_regs_pkg::reg_data_t model [5];
  string reg_names [5] = '{"reg_led", "reg_spi_mux", "reg_sr_4094", "reg_mode",
    "reg_test_pattern"};

  // position of an address in the output list, -1 when unmapped
  function automatic int reg_index(input spi_regs_pkg::reg_addr_t a);
    case (a)
      spi_regs_pkg::ADDR_LED: return 0;
      spi_regs_pkg::ADDR_SPI_MUX: return 1;
      spi_regs_pkg::ADDR_SR_4094: return 2;
      spi_regs_pkg::ADDR_MODE: return 3;
      spi_regs_pkg::ADDR_TEST_PATTERN: return 4;
      default: return -1;
    endcase
  endfunction

  function automatic spi_regs_pkg::reg_data_t reg_out(input int idx);
    case (idx)
      0: return reg_led;
      1: return reg_spi_mux;
      2: return reg_sr_4094;
      3: return reg_mode;
      default: return reg_test_pattern;
    endcase
  endfunction

  task automatic compare(input string name, input spi_regs_pkg::reg_data_t expv,
    input spi_regs_pkg::reg_data_t got);
    if (got !== expv)
    begin
      $display("ERROR t=%0t %s expected=%06h got=%06h", $time, name, expv, got);
      err_count = err_count + 1;
    end
  endtask

  initial
  begin
    int idx;
    err_count = 0;
    check_count = 0;
    // reset state, leds alternate and everything else is clear
    model[0] = 24'hAAAAAA;
    for (int i = 1; i < 5; i++)
      model[i] = '0;
    forever
    begin
      @(negedge spi_cs_n);
      bit_cnt = 0;
      rd_word = '0;
      while (spi_cs_n == 1'b0)
      begin
        @(posedge sclk or posedge spi_cs_n);
        if (spi_cs_n == 1'b0)
        begin
          bit_cnt = bit_cnt + 1;
          // data phase starts on the 17th rise, msb first
          if (bit_cnt > spi_regs_pkg::FRAME_BITS - spi_regs_pkg::DATA_W
            && bit_cnt <= spi_regs_pkg::FRAME_BITS)
            rd_word = {rd_word[spi_regs_pkg::DATA_W-2:0], miso};
        end
      end
      // a write shows on the outputs 5 cycles after chip select rises
      repeat (10) @(posedge cs);
      idx = reg_index(exp_addr);
      if (exp_kind == "R")
      begin
        if (bit_cnt != spi_regs_pkg::FRAME_BITS)
        begin
          $display("read frame ended after %0d bits instead of a full frame", bit_cnt);
          err_count = err_count + 1;
        end
        else
          compare("miso", exp_value, rd_word);
      end
      // only a mapped address moves the expected state
      if (idx >= 0)
        model[idx] = exp_value;
      // every output must hold its expected state after each frame
      for (int i = 0; i < 5; i++)
        compare(reg_names[i], model[i], reg_out(i));
      check_count = check_count + 1;
    end
  end

endmodule

// File: spi_regs_props.sv
// frame engine assertions
// write strobe shape and bit counter bound, bound into spi_frame_engine
`timescale 1ns/100ps

module spi_regs_props (
  input  logic cs,
  input  logic rst_n,
  input  logic frame_start,
  input  logic wr_en,
  input  spi_regs_pkg::frame_state_t state,
  input  logic [5:0] bit_cnt
);

  // one strobe per committed frame, the register file has no acknowledge
  a_wr_en_pulse: assert property (@(posedge cs) disable iff (!rst_n)
    wr_en |=> !wr_en)
    else $error("wr_en stayed high for more than one cycle");

  // a write never lands on the first cycle of a new frame
  a_wr_en_not_at_start: assert property (@(posedge cs) disable iff (!rst_n)
    !(wr_en && frame_start))
    else $error("wr_en fired together with frame_start");

  // the counter saturates at a full frame
  a_bit_cnt_bound: assert property (@(posedge cs) disable iff (!rst_n)
    (state == spi_regs_pkg::ST_DATA) |-> (bit_cnt <= 6'(spi_regs_pkg::FRAME_BITS)))
    else $error("bit count ran past a full frame in the data state");

endmodule

bind spi_frame_engine spi_regs_props spi_regs_props_inst (
  .cs          (cs),
  .rst_n       (rst_n),
  .frame_start (frame_start),
  .wr_en       (bus.wr_en),
  .state       (state),
  .bit_cnt     (bit_cnt)
);

// File: spi_regs_top.sv
// spi register block top level
// pin synchronizer, frame engine and register file on the cs clock
`timescale 1ns/100ps

module spi_regs_top (
  input  logic cs,
  input  logic rst_n,
  input  logic sclk,
  input  logic spi_cs_n,
  input  logic mosi,
  output logic miso,
  output spi_regs_pkg::reg_data_t reg_led,
  output spi_regs_pkg::reg_data_t reg_spi_mux,
  output spi_regs_pkg::reg_data_t reg_sr_4094,
  output spi_regs_pkg::reg_data_t reg_mode,
  output spi_regs_pkg::reg_data_t reg_test_pattern
);

  // synchronized pin events
  logic sclk_rise;
  logic sclk_fall;
  logic frame_start;
  logic frame_end;
  logic mosi_bit;

  // engine to register file path
  reg_bus_if reg_bus ();

  spi_sync spi_sync_inst (
    .cs          (cs),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .spi_cs_n    (spi_cs_n),
    .mosi        (mosi),
    .sclk_rise   (sclk_rise),
    .sclk_fall   (sclk_fall),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .mosi_bit    (mosi_bit)
  );

  spi_frame_engine spi_frame_engine_inst (
    .cs          (cs),
    .rst_n       (rst_n),
    .sclk_rise   (sclk_rise),
    .sclk_fall   (sclk_fall),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .mosi_bit    (mosi_bit),
    .miso        (miso),
    .bus         (reg_bus)
  );

  reg_file reg_file_inst (
    .cs               (cs),
    .rst_n            (rst_n),
    .bus              (reg_bus),
    .reg_led          (reg_led),
    .reg_spi_mux      (reg_spi_mux),
    .reg_sr_4094      (reg_sr_4094),
    .reg_mode         (reg_mode),
    .reg_test_pattern (reg_test_pattern)
  );

endmodule

// File: reg_file.sv
// control register file
// five 24-bit registers with write, set, clear and toggle updates and a read mux
`timescale 1ns/100ps

module reg_file (
  input  logic cs,
  input  logic rst_n,
  reg_bus_if.regs bus,
  output spi_regs_pkg::reg_data_t reg_led,
  output spi_regs_pkg::reg_data_t reg_spi_mux,
  output spi_regs_pkg::reg_data_t reg_sr_4094,
  output spi_regs_pkg::reg_data_t reg_mode,
  output spi_regs_pkg::reg_data_t reg_test_pattern
);

  // next value of one register under the given op
  function automatic spi_regs_pkg::reg_data_t apply_op(
    input spi_regs_pkg::reg_data_t cur,
    input spi_regs_pkg::reg_data_t val,
    input spi_regs_pkg::wr_op_t op
  );
    spi_regs_pkg::reg_data_t res;
    case (op)
      spi_regs_pkg::OP_WRITE: res = val;
      // or in the ones of val
      spi_regs_pkg::OP_SET: res = cur | val;
      // knock out the ones of val
      spi_regs_pkg::OP_CLEAR: res = cur & ~val;
      spi_regs_pkg::OP_TOGGLE: res = cur ^ val;
      default: res = val;
    endcase
    return res;
  endfunction

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reg_led <= spi_regs_pkg::LED_RESET;
      // no spi device selected
      reg_spi_mux <= '0;
      reg_sr_4094 <= '0;
      reg_mode <= '0;
      reg_test_pattern <= '0;
    end
    else if (bus.wr_en)
    begin
      // unmapped addresses fall through untouched
      case (bus.addr)
        spi_regs_pkg::ADDR_LED:
          reg_led <= apply_op(reg_led, bus.wdata, bus.wr_op);
        spi_regs_pkg::ADDR_SPI_MUX:
          reg_spi_mux <= apply_op(reg_spi_mux, bus.wdata, bus.wr_op);
        spi_regs_pkg::ADDR_SR_4094:
          reg_sr_4094 <= apply_op(reg_sr_4094, bus.wdata, bus.wr_op);
        spi_regs_pkg::ADDR_MODE:
          reg_mode <= apply_op(reg_mode, bus.wdata, bus.wr_op);
        spi_regs_pkg::ADDR_TEST_PATTERN:
          reg_test_pattern <= apply_op(reg_test_pattern, bus.wdata, bus.wr_op);
        default:
        begin
        end
      endcase
    end
  end

  // read mux, valid the cycle after the engine latches addr
  always_comb
  begin
    case (bus.addr)
      spi_regs_pkg::ADDR_LED: bus.rdata = reg_led;
      spi_regs_pkg::ADDR_SPI_MUX: bus.rdata = reg_spi_mux;
      spi_regs_pkg::ADDR_SR_4094: bus.rdata = reg_sr_4094;
      spi_regs_pkg::ADDR_MODE: bus.rdata = reg_mode;
      spi_regs_pkg::ADDR_TEST_PATTERN: bus.rdata = reg_test_pattern;
      // recognizable filler for holes in the map
      default: bus.rdata = spi_regs_pkg::UNMAPPED_READ;
    endcase
  end

endmodule

// File: spi_frame_engine.sv
// spi frame engine
// shifts 40-bit frames in and read data out, issues register writes at frame end
`timescale 1ns/100ps

module spi_frame_engine (
  input  logic cs,
  input  logic rst_n,
  input  logic sclk_rise,
  input  logic sclk_fall,
  input  logic frame_start,
  input  logic frame_end,
  input  logic mosi_bit,
  output logic miso,
  reg_bus_if.engine bus
);

  spi_regs_pkg::frame_state_t state;
  // rises seen in this frame, tops out at FRAME_BITS
  logic [5:0] bit_cnt;
  // frame receive shift register, first bit ends up in the msb
  logic [spi_regs_pkg::FRAME_BITS-1:0] rx_shift;
  logic [spi_regs_pkg::FRAME_BITS-1:0] rx_next;
  // read data on its way to miso
  spi_regs_pkg::reg_data_t tx_shift;
  // one cycle after the address latch, rdata is valid
  logic load_tx;
  logic read_flag;
  logic commit;

  assign rx_next = {rx_shift[spi_regs_pkg::FRAME_BITS-2:0], mosi_bit};
  assign read_flag = rx_shift[spi_regs_pkg::FRAME_BITS-1];

  // write only a complete frame with the read flag clear
  assign commit = frame_end && !frame_start
    && (state == spi_regs_pkg::ST_DATA)
    && (bit_cnt == 6'(spi_regs_pkg::FRAME_BITS))
    && !read_flag;

  // value field and op code straight from the frozen receive register
  assign bus.wdata = rx_shift[spi_regs_pkg::DATA_W-1:0];
  assign bus.wr_op = rx_shift[spi_regs_pkg::DATA_W+1:spi_regs_pkg::DATA_W];

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= spi_regs_pkg::ST_IDLE;
      bit_cnt <= '0;
      load_tx <= 1'b0;
      bus.wr_en <= 1'b0;
      bus.addr <= '0;
    end
    else
    begin
      load_tx <= 1'b0;
      bus.wr_en <= commit;
      if (frame_start)
      begin
        // restart from any state, a partial frame is simply dropped
        state <= spi_regs_pkg::ST_HEADER;
        bit_cnt <= '0;
      end
      else if (frame_end)
      begin
        state <= spi_regs_pkg::ST_IDLE;
      end
      else if (sclk_rise)
      begin
        case (state)
          spi_regs_pkg::ST_HEADER:
          begin
            bit_cnt <= bit_cnt + 6'd1;
            // 8th rise completes flag and address
            if (bit_cnt == 6'(spi_regs_pkg::ADDR_W))
            begin
              bus.addr <= rx_next[spi_regs_pkg::ADDR_W-1:0];
              load_tx <= 1'b1;
              state <= spi_regs_pkg::ST_PAD;
            end
          end
          spi_regs_pkg::ST_PAD:
          begin
            bit_cnt <= bit_cnt + 6'd1;
            // 16th rise ends the pad byte
            if (bit_cnt == 6'(spi_regs_pkg::FRAME_BITS - spi_regs_pkg::DATA_W - 1))
            begin
              state <= spi_regs_pkg::ST_DATA;
            end
          end
          spi_regs_pkg::ST_DATA:
          begin
            // an extra bit makes the frame too long, drop it
            if (bit_cnt == 6'(spi_regs_pkg::FRAME_BITS))
              state <= spi_regs_pkg::ST_IDLE;
            else
              bit_cnt <= bit_cnt + 6'd1;
          end
          default:
          begin
          end
        endcase
      end
    end
  end

  // payload shifters
  always_ff @(posedge cs)
  begin
    if (sclk_rise && (state != spi_regs_pkg::ST_IDLE))
      rx_shift <= rx_next;
    if (load_tx)
      tx_shift <= bus.rdata;
    else if (sclk_fall && (state == spi_regs_pkg::ST_DATA))
      tx_shift <= tx_shift << 1;
  end

  // miso moves one cycle after each fall of the data phase
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
      miso <= 1'b0;
    else if (frame_start || frame_end)
      miso <= 1'b0;
    else if (sclk_fall && (state == spi_regs_pkg::ST_DATA))
      miso <= tx_shift[spi_regs_pkg::DATA_W-1];
  end

endmodule

// File: spi_sync.sv
// spi pin synchronizer
// two-flop sync of sclk, spi_cs_n and mosi, plus registered edge pulses
`timescale 1ns/100ps

module spi_sync (
  input  logic cs,
  input  logic rst_n,
  input  logic sclk,
  input  logic spi_cs_n,
  input  logic mosi,
  output logic sclk_rise,
  output logic sclk_fall,
  output logic frame_start,
  output logic frame_end,
  output logic mosi_bit
);

  // two-stage chains, bit 1 is the synchronized level
  logic [1:0] sclk_sync;
  logic [1:0] cs_n_sync;
  logic [1:0] mosi_sync;
  // previous synchronized levels for edge compare
  logic sclk_prev;
  logic cs_n_prev;

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // idle bus levels, clock low and chip select high
      sclk_sync <= 2'b00;
      cs_n_sync <= 2'b11;
      mosi_sync <= 2'b00;
      sclk_prev <= 1'b0;
      cs_n_prev <= 1'b1;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      frame_start <= 1'b0;
      frame_end <= 1'b0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_n_sync <= {cs_n_sync[0], spi_cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_prev <= sclk_sync[1];
      cs_n_prev <= cs_n_sync[1];
      // registered pulses, 3 cs cycles behind the pin edge
      sclk_rise <= sclk_sync[1] & ~sclk_prev;
      sclk_fall <= ~sclk_sync[1] & sclk_prev;
      // chip select low starts a frame, high ends it
      frame_start <= ~cs_n_sync[1] & cs_n_prev;
      frame_end <= cs_n_sync[1] & ~cs_n_prev;
    end
  end

  // mosi is stable for a half period around each rise
  assign mosi_bit = mosi_sync[1];

endmodule

// File: reg_bus_if.sv
// register access bus between the spi frame engine and the register file
// single-cycle write strobe, no acknowledge, combinational read data
`timescale 1ns/100ps

interface reg_bus_if;

  // write strobe, one cs cycle per committed frame
  logic wr_en;
  // set, clear, toggle or plain write
  spi_regs_pkg::wr_op_t wr_op;
  // shared by read and write, latched after the header byte
  spi_regs_pkg::reg_addr_t addr;
  spi_regs_pkg::reg_data_t wdata;
  // combinational read of addr
  spi_regs_pkg::reg_data_t rdata;

  // frame engine side
  modport engine (
    output wr_en,
    output wr_op,
    output addr,
    output wdata,
    input  rdata
  );

  // register file side
  modport regs (
    input  wr_en,
    input  wr_op,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// File: spi_regs_pkg.sv
// spi register block shared definitions
// frame geometry, register map, write op codes and frame engine states
package spi_regs_pkg;

  // one frame is flag + address, pad byte, then the 24-bit value
  localparam int FRAME_BITS = 40;
  // address field width, low bits of the header byte
  localparam int ADDR_W = 7;
  // register and data field width
  localparam int DATA_W = 24;

  typedef logic [ADDR_W-1:0] reg_addr_t;
  typedef logic [DATA_W-1:0] reg_data_t;
  // op code carried in the two low pad bits
  typedef logic [1:0] wr_op_t;

  localparam wr_op_t OP_WRITE = 2'd0;
  localparam wr_op_t OP_SET = 2'd1;
  localparam wr_op_t OP_CLEAR = 2'd2;
  localparam wr_op_t OP_TOGGLE = 2'd3;

  // register map
  localparam reg_addr_t ADDR_LED = 7'd7;
  localparam reg_addr_t ADDR_SPI_MUX = 7'd8;
  localparam reg_addr_t ADDR_SR_4094 = 7'd9;
  localparam reg_addr_t ADDR_MODE = 7'd12;
  localparam reg_addr_t ADDR_TEST_PATTERN = 7'd14;

  // alternating pattern so the leds show life out of reset
  localparam reg_data_t LED_RESET = 24'hAAAAAA;
  // returned for any address outside the map
  localparam reg_data_t UNMAPPED_READ = 24'h0F0F0F;

  // frame engine states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HEADER,
    ST_PAD,
    ST_DATA
  } frame_state_t;

endpackage
